// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;
    // addi x0, x0, 0
    localparam logic [ilen-1:0] nop_inst = 32'h0000_0013;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_t;

    typedef struct packed {
        logic    reg_we;
        logic    mem_we;
        logic    mem_re;
        logic    is_branch;
        logic    is_jal;
        logic    bne;
        logic    use_imm;
        logic    use_rs1;
        logic    use_rs2;
        alu_op_t alu_op;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } id_exe_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
    } exe_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        logic                  reg_we;
        logic [reg_addr_w-1:0] rd;
        wb_sel_t               wb_sel;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
        logic [xlen-1:0]       pc4;
    } mem_wb_t;

endpackage

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = core_pkg::if_id_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t d,
    output logic     out_valid,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // payload advances unless the stage holds
    always_ff @(posedge clk) begin
        if (flush || !stall) begin
            q <= d;
        end
    end

    a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid);

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic [core_pkg::ilen-1:0]       inst,
    output core_pkg::ctrl_t                 ctrl,
    output logic [core_pkg::xlen-1:0]       imm,
    output logic [core_pkg::reg_addr_w-1:0] rd,
    output logic [core_pkg::reg_addr_w-1:0] rs1,
    output logic [core_pkg::reg_addr_w-1:0] rs2
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];
    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            opc_op: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_5 ? alu_sub : alu_add;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl = '0;
                endcase
            end
            opc_op_imm: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_imm = 1'b1;
                imm = {{(xlen-12){inst[31]}}, inst[31:20]};
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl = '0;
                endcase
            end
            opc_load: begin
                ctrl.reg_we  = 1'b1;
                ctrl.mem_re  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel  = wb_load;
                imm = {{(xlen-12){inst[31]}}, inst[31:20]};
            end
            opc_store: begin
                ctrl.mem_we  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                ctrl.use_imm = 1'b1;
                imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            opc_branch: begin
                // beq / bne only
                if (funct3[2:1] == 2'b00) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.bne       = funct3[0];
                    ctrl.use_rs1   = 1'b1;
                    ctrl.use_rs2   = 1'b1;
                end
                imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opc_jal: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = wb_pc4;
                imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [63:0] wdata,
    output logic [63:0] rdata1,
    output logic [63:0] rdata2
);

    // x0 has no storage
    logic [63:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is visible to decode
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

    a_wdata_known: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(wdata));

endmodule

// ==== verilog/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
    input  logic [core_pkg::reg_addr_w-1:0] rs1,
    input  logic [core_pkg::reg_addr_w-1:0] rs2,
    input  logic [core_pkg::xlen-1:0]       rf_rdata1,
    input  logic [core_pkg::xlen-1:0]       rf_rdata2,
    input  logic [core_pkg::reg_addr_w-1:0] exe_rd,
    input  logic                            exe_reg_we,
    input  logic [core_pkg::xlen-1:0]       exe_result,
    input  logic [core_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                            mem_reg_we,
    input  logic [core_pkg::xlen-1:0]       mem_result,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                            wb_reg_we,
    input  logic [core_pkg::xlen-1:0]       wb_result,
    output logic [core_pkg::xlen-1:0]       rs1_data,
    output logic [core_pkg::xlen-1:0]       rs2_data
);
    import core_pkg::*;

    // youngest in-flight writer is applied last and wins
    always_comb begin
        rs1_data = rf_rdata1;
        rs2_data = rf_rdata2;
        if (rs1 != '0) begin
            if (wb_reg_we && wb_rd == rs1) rs1_data = wb_result;
            if (mem_reg_we && mem_rd == rs1) rs1_data = mem_result;
            if (exe_reg_we && exe_rd == rs1) rs1_data = exe_result;
        end
        if (rs2 != '0) begin
            if (wb_reg_we && wb_rd == rs2) rs2_data = wb_result;
            if (mem_reg_we && mem_rd == rs2) rs2_data = mem_result;
            if (exe_reg_we && exe_rd == rs2) rs2_data = exe_result;
        end
    end

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic [core_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [core_pkg::reg_addr_w-1:0] id_rs2,
    input  logic                            id_use_rs1,
    input  logic                            id_use_rs2,
    input  logic                            exe_valid,
    input  logic                            exe_mem_re,
    input  logic [core_pkg::reg_addr_w-1:0] exe_rd,
    input  logic                            redirect,
    output logic                            stall_pc,
    output logic                            stall_if_id,
    output logic                            flush_if_id,
    output logic                            flush_id_exe
);

    logic load_use;

    // load data only exists from the memory stage on
    assign load_use = exe_valid && exe_mem_re && exe_rd != '0 &&
                      ((id_use_rs1 && id_rs1 == exe_rd) ||
                       (id_use_rs2 && id_rs2 == exe_rd));

    assign stall_pc     = load_use && !redirect;
    assign stall_if_id  = load_use && !redirect;
    assign flush_if_id  = redirect;
    assign flush_id_exe = redirect || load_use;

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                      valid,
    input  logic [core_pkg::xlen-1:0] pc,
    input  logic [core_pkg::xlen-1:0] rs1_data,
    input  logic [core_pkg::xlen-1:0] rs2_data,
    input  logic [core_pkg::xlen-1:0] imm,
    input  core_pkg::ctrl_t           ctrl,
    output logic [core_pkg::xlen-1:0] result,
    output logic [core_pkg::xlen-1:0] redirect_pc,
    output logic                      redirect
);
    import core_pkg::*;

    logic [xlen-1:0] op_b;
    logic            equal;

    assign op_b = ctrl.use_imm ? imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: result = rs1_data - op_b;
            alu_and: result = rs1_data & op_b;
            alu_or:  result = rs1_data | op_b;
            alu_xor: result = rs1_data ^ op_b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            default: result = rs1_data + op_b;
        endcase
    end

    // branch compare always on registers
    assign equal       = rs1_data == rs2_data;
    assign redirect_pc = pc + imm;
    assign redirect    = valid && (ctrl.is_jal || (ctrl.is_branch && (equal != ctrl.bne)));

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                            clk,
    input  logic                            rst_n,
    output logic [core_pkg::xlen-1:0]       pc,
    input  logic [core_pkg::ilen-1:0]       inst,
    output logic [core_pkg::xlen-1:0]       address,
    output logic                            mem_we,
    output logic                            mem_re,
    output logic [core_pkg::xlen-1:0]       wdata,
    input  logic [core_pkg::xlen-1:0]       rdata,
    output logic                            commit_valid,
    output logic [core_pkg::xlen-1:0]       commit_pc,
    output logic [core_pkg::ilen-1:0]       commit_inst,
    output logic                            commit_rd_we,
    output logic [core_pkg::reg_addr_w-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]       commit_rd_data
);
    import core_pkg::*;

    logic stall_pc;
    logic stall_if_id;
    logic flush_if_id;
    logic flush_id_exe;
    logic redirect;
    logic [xlen-1:0] redirect_pc;

    if_id_t   if_id_d, if_id_q;
    id_exe_t  id_exe_d, id_exe_q;
    exe_mem_t exe_mem_d, exe_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;
    logic id_valid;
    logic exe_valid;
    logic mem_valid;
    logic wb_valid;

    logic [ilen-1:0]       id_inst;
    ctrl_t                 id_ctrl;
    logic [xlen-1:0]       id_imm;
    logic [reg_addr_w-1:0] id_rd, id_rs1, id_rs2;
    logic [xlen-1:0]       rf_rdata1, rf_rdata2;
    logic [xlen-1:0]       id_rs1_data, id_rs2_data;

    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] exe_result;
    logic [xlen-1:0] mem_result;
    logic [xlen-1:0] wb_data;
    logic exe_reg_we;
    logic mem_reg_we;
    logic wb_reg_we;

    // fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall_pc) begin
            pc <= pc + xlen'(4);
        end
    end

    assign if_id_d = '{pc: pc, inst: inst};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall_if_id), .flush(flush_if_id),
        .in_valid(1'b1), .d(if_id_d), .out_valid(id_valid), .q(if_id_q)
    );

    // decode, bubbles look like a nop
    assign id_inst = id_valid ? if_id_q.inst : nop_inst;

    decoder u_decoder (
        .inst(id_inst), .ctrl(id_ctrl), .imm(id_imm),
        .rd(id_rd), .rs1(id_rs1), .rs2(id_rs2)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .we(wb_reg_we), .waddr(mem_wb_q.rd),
        .raddr1(id_rs1), .raddr2(id_rs2), .wdata(wb_data),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    forward_unit u_forward_unit (
        .rs1(id_rs1), .rs2(id_rs2), .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .exe_rd(id_exe_q.rd), .exe_reg_we(exe_reg_we), .exe_result(exe_result),
        .mem_rd(exe_mem_q.rd), .mem_reg_we(mem_reg_we), .mem_result(mem_result),
        .wb_rd(mem_wb_q.rd), .wb_reg_we(wb_reg_we), .wb_result(wb_data),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
    );

    hazard_unit u_hazard_unit (
        .id_rs1(id_rs1), .id_rs2(id_rs2),
        .id_use_rs1(id_ctrl.use_rs1), .id_use_rs2(id_ctrl.use_rs2),
        .exe_valid(exe_valid), .exe_mem_re(id_exe_q.ctrl.mem_re),
        .exe_rd(id_exe_q.rd), .redirect(redirect),
        .stall_pc(stall_pc), .stall_if_id(stall_if_id),
        .flush_if_id(flush_if_id), .flush_id_exe(flush_id_exe)
    );

    assign id_exe_d = '{pc: if_id_q.pc, inst: id_inst, ctrl: id_ctrl, rd: id_rd,
                        rs1_data: id_rs1_data, rs2_data: id_rs2_data, imm: id_imm};

    pipe_reg #(.payload_t(id_exe_t)) id_exe_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_id_exe),
        .in_valid(id_valid), .d(id_exe_d), .out_valid(exe_valid), .q(id_exe_q)
    );

    // execute
    execute_unit u_execute_unit (
        .valid(exe_valid), .pc(id_exe_q.pc), .rs1_data(id_exe_q.rs1_data),
        .rs2_data(id_exe_q.rs2_data), .imm(id_exe_q.imm), .ctrl(id_exe_q.ctrl),
        .result(alu_result), .redirect_pc(redirect_pc), .redirect(redirect)
    );

    // jal link value rides in the result field from here on
    assign exe_result = id_exe_q.ctrl.is_jal ? id_exe_q.pc + xlen'(4) : alu_result;
    assign exe_reg_we = exe_valid && id_exe_q.ctrl.reg_we;

    assign exe_mem_d = '{pc: id_exe_q.pc, inst: id_exe_q.inst, ctrl: id_exe_q.ctrl,
                         rd: id_exe_q.rd, alu_result: exe_result,
                         store_data: id_exe_q.rs2_data};

    pipe_reg #(.payload_t(exe_mem_t)) exe_mem_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .in_valid(exe_valid), .d(exe_mem_d), .out_valid(mem_valid), .q(exe_mem_q)
    );

    // memory
    assign address    = exe_mem_q.alu_result;
    assign wdata      = exe_mem_q.store_data;
    assign mem_we     = mem_valid && exe_mem_q.ctrl.mem_we;
    assign mem_re     = mem_valid && exe_mem_q.ctrl.mem_re;
    assign mem_reg_we = mem_valid && exe_mem_q.ctrl.reg_we;
    assign mem_result = (exe_mem_q.ctrl.wb_sel == wb_load) ? rdata : exe_mem_q.alu_result;

    assign mem_wb_d = '{pc: exe_mem_q.pc, inst: exe_mem_q.inst,
                        reg_we: exe_mem_q.ctrl.reg_we, rd: exe_mem_q.rd,
                        wb_sel: exe_mem_q.ctrl.wb_sel, alu_result: exe_mem_q.alu_result,
                        load_data: rdata, pc4: exe_mem_q.pc + xlen'(4)};

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .in_valid(mem_valid), .d(mem_wb_d), .out_valid(wb_valid), .q(mem_wb_q)
    );

    // writeback
    always_comb begin
        case (mem_wb_q.wb_sel)
            wb_load: wb_data = mem_wb_q.load_data;
            wb_pc4:  wb_data = mem_wb_q.pc4;
            default: wb_data = mem_wb_q.alu_result;
        endcase
    end

    assign wb_reg_we = wb_valid && mem_wb_q.reg_we;

    assign commit_valid   = wb_valid;
    assign commit_pc      = mem_wb_q.pc;
    assign commit_inst    = mem_wb_q.inst;
    assign commit_rd_we   = wb_reg_we;
    assign commit_rd      = mem_wb_q.rd;
    assign commit_rd_data = wb_data;

    a_mem_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we && mem_re));

endmodule

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int n_tests  = 6;
    localparam int max_wait = 200;
    // jal x0, 0
    localparam logic [31:0] loop_inst = {25'd0, opc_jal};

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic [xlen-1:0]       pc;
    logic [ilen-1:0]       inst;
    logic [xlen-1:0]       address;
    logic                  mem_we;
    logic                  mem_re;
    logic [xlen-1:0]       wdata;
    logic [xlen-1:0]       rdata;
    logic                  commit_valid;
    logic [xlen-1:0]       commit_pc;
    logic [ilen-1:0]       commit_inst;
    logic                  commit_rd_we;
    logic [reg_addr_w-1:0] commit_rd;
    logic [xlen-1:0]       commit_rd_data;

    logic [31:0] rom [64];
    logic [63:0] ram [32];
    logic [63:0] shadow [32];

    string       tname [n_tests];
    logic [31:0] tprog [n_tests][8];
    int          exp_reg [n_tests];
    logic [63:0] exp_val [n_tests];
    int          exp_count [n_tests];
    logic        exp_store [n_tests];
    logic [63:0] st_addr [n_tests];
    logic [63:0] st_data [n_tests];

    int t;
    int test_errors;
    int passed;
    int failed;
    bit timed_out;

    always #2 clk = ~clk;

    core_top uut (
        .clk(clk), .rst_n(rst_n), .pc(pc), .inst(inst),
        .address(address), .mem_we(mem_we), .mem_re(mem_re), .wdata(wdata), .rdata(rdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
        .commit_rd_we(commit_rd_we), .commit_rd(commit_rd), .commit_rd_data(commit_rd_data)
    );

    // same-cycle instruction ROM and data RAM
    assign inst  = rom[pc[7:2]];
    assign rdata = ram[address[7:3]];

    always @(posedge clk) begin
        if (mem_we) begin
            ram[address[7:3]] <= wdata;
        end
    end

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b011, s[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        logic [20:0] j;
        j = 21'(imm);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), opc_jal};
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Error %s: %s expected %h, got %h", tname[t], what, exp, act);
        test_errors++;
    endtask

    task automatic report_problem(input string text);
        $display("%s: %s", tname[t], text);
        test_errors++;
    endtask

    task automatic fill_table();
        for (int k = 0; k < n_tests; k++) begin
            for (int i = 0; i < 8; i++) begin
                tprog[k][i] = nop_inst;
            end
            exp_store[k] = 1'b0;
            st_addr[k]   = '0;
            st_data[k]   = '0;
        end
        // registers read back as zero after reset
        tname[0] = "reset";
        tprog[0][0] = r_type(0, 3, 2, 0, 1);
        tprog[0][1] = loop_inst;
        exp_reg[0] = 1;
        exp_val[0] = 64'd0;
        exp_count[0] = 2;

        // each op reads the result just before it
        tname[1] = "alu_chain";
        tprog[1][0] = i_type(12, 0, 0, 1, opc_op_imm);
        tprog[1][1] = r_type(0, 1, 1, 0, 2);
        tprog[1][2] = r_type(32, 2, 1, 0, 3);
        tprog[1][3] = r_type(0, 2, 3, 4, 4);
        tprog[1][4] = r_type(0, 1, 4, 7, 5);
        tprog[1][5] = r_type(0, 2, 5, 6, 6);
        tprog[1][6] = r_type(0, 6, 4, 2, 7);
        tprog[1][7] = loop_inst;
        exp_reg[1] = 7;
        exp_val[1] = 64'd1;
        exp_count[1] = 8;

        tname[2] = "imm_ops_x0";
        tprog[2][0] = i_type(5, 0, 0, 0, opc_op_imm);
        tprog[2][1] = i_type(3, 0, 0, 1, opc_op_imm);
        tprog[2][2] = i_type(6, 1, 4, 2, opc_op_imm);
        tprog[2][3] = i_type(8, 2, 6, 3, opc_op_imm);
        tprog[2][4] = i_type(-2, 3, 7, 4, opc_op_imm);
        tprog[2][5] = loop_inst;
        exp_reg[2] = 4;
        exp_val[2] = 64'd12;
        exp_count[2] = 6;

        tname[3] = "store_load";
        tprog[3][0] = i_type(40, 0, 0, 1, opc_op_imm);
        tprog[3][1] = i_type(-7, 0, 0, 2, opc_op_imm);
        tprog[3][2] = s_type(0, 2, 1);
        tprog[3][3] = i_type(0, 1, 3, 3, opc_load);
        tprog[3][4] = r_type(0, 1, 3, 0, 4);
        tprog[3][5] = loop_inst;
        exp_reg[3] = 4;
        exp_val[3] = 64'd33;
        exp_count[3] = 6;
        exp_store[3] = 1'b1;
        st_addr[3] = 64'd40;
        st_data[3] = 64'hffff_ffff_ffff_fff9;

        // bne falls through, beq skips two addi
        tname[4] = "branch";
        tprog[4][0] = i_type(5, 0, 0, 1, opc_op_imm);
        tprog[4][1] = i_type(5, 0, 0, 2, opc_op_imm);
        tprog[4][2] = b_type(8, 2, 1, 1);
        tprog[4][3] = b_type(12, 2, 1, 0);
        tprog[4][4] = i_type(1, 0, 0, 3, opc_op_imm);
        tprog[4][5] = i_type(1, 0, 0, 4, opc_op_imm);
        tprog[4][6] = i_type(9, 0, 0, 5, opc_op_imm);
        tprog[4][7] = loop_inst;
        exp_reg[4] = 3;
        exp_val[4] = 64'd0;
        exp_count[4] = 6;

        tname[5] = "jal";
        tprog[5][0] = i_type(1, 0, 0, 1, opc_op_imm);
        tprog[5][1] = j_type(12, 5);
        tprog[5][2] = i_type(1, 0, 0, 2, opc_op_imm);
        tprog[5][3] = i_type(2, 0, 0, 2, opc_op_imm);
        tprog[5][4] = r_type(0, 1, 5, 0, 6);
        tprog[5][5] = loop_inst;
        exp_reg[5] = 6;
        exp_val[5] = 64'd9;
        exp_count[5] = 4;
    endtask

    task automatic restart_with_program(input int idx);
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < 8) ? tprog[idx][i] : nop_inst;
        end
        for (int i = 0; i < 32; i++) begin
            ram[i]    = {32'h0ace_0000 + i, 32'h5eed_0000 + i};
            shadow[i] = '0;
        end
        repeat (2) begin
            @(negedge clk);
            if (pc !== reset_pc) report_mismatch("pc in reset", reset_pc, pc);
            if (commit_valid !== 1'b0) begin
                report_mismatch("commit_valid in reset", 0, commit_valid);
            end
            if (mem_we !== 1'b0) report_mismatch("mem_we in reset", 0, mem_we);
            if (mem_re !== 1'b0) report_mismatch("mem_re in reset", 0, mem_re);
        end
        rst_n = 1'b1;
        if (pc !== reset_pc) report_mismatch("pc after reset", reset_pc, pc);
    endtask

    task automatic run_program(output int retired, output bit finished);
        int cycles;
        bit store_seen;
        cycles     = 0;
        retired    = 0;
        finished   = 1'b0;
        store_seen = 1'b0;
        while (!finished && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
            if (mem_we === 1'b1) begin
                store_seen = 1'b1;
                if (!exp_store[t]) begin
                    report_problem("a store reached the memory port in a program without one");
                end else begin
                    if (address !== st_addr[t]) begin
                        report_mismatch("store address", st_addr[t], address);
                    end
                    if (wdata !== st_data[t]) begin
                        report_mismatch("store data", st_data[t], wdata);
                    end
                end
            end
            if (commit_valid === 1'b1) begin
                retired++;
                // first instruction retires four edges after reset
                if (retired == 1 && cycles != 4) begin
                    report_mismatch("first retire cycle", 4, cycles);
                end
                // the retired word is the one the program holds at that pc
                if (commit_inst !== rom[commit_pc[7:2]]) begin
                    report_mismatch($sformatf("inst retired at pc %0h", commit_pc),
                                    rom[commit_pc[7:2]], commit_inst);
                end
                if (commit_rd_we && commit_rd != '0) shadow[commit_rd] = commit_rd_data;
                if (commit_inst === loop_inst) finished = 1'b1;
            end
        end
        if (exp_store[t] && !store_seen) begin
            report_problem("the expected store never reached the memory port");
        end
    endtask

    initial begin
        int retired;
        bit finished;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        fill_table();
        for (int i = 0; i < 64; i++) begin
            rom[i] = nop_inst;
        end
        for (t = 0; t < n_tests && !timed_out; t++) begin
            test_errors = 0;
            restart_with_program(t);
            run_program(retired, finished);
            if (!finished) begin
                $display("%s: the end loop did not retire within %0d cycles",
                         tname[t], max_wait);
                timed_out = 1'b1;
                test_errors++;
            end else begin
                if (retired != exp_count[t]) begin
                    report_mismatch("retire count", exp_count[t], retired);
                end
                if (shadow[exp_reg[t]] !== exp_val[t]) begin
                    report_mismatch($sformatf("x%0d", exp_reg[t]), exp_val[t], shadow[exp_reg[t]]);
                end
            end
            if (test_errors == 0) begin
                passed++;
                $display("%s: ok", tname[t]);
            end else begin
                failed++;
                $display("%s: %0d check(s) failed", tname[t], test_errors);
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/core_pkg.sv
verilog/pipe_reg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/forward_unit.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/core_top.sv
sim/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_pipe_core

sources:
  - verilog/core_pkg.sv
  - verilog/pipe_reg.sv
  - verilog/decoder.sv
  - verilog/reg_file.sv
  - verilog/forward_unit.sv
  - verilog/hazard_unit.sv
  - verilog/execute_unit.sv
  - verilog/core_top.sv
  - target: simulation
    files:
      - sim/core_tb.sv
